// ==== list.f ====
common/axi_regs_pkg.sv
source/reg_bank.sv
axi_slave/axi_write_channel.sv
axi_slave/axi_read_channel.sv
source/axi_lite_regs.sv
dv/axi_lite_regs_assertions.sv
dv/tb_axi_lite_regs.sv

// ==== run.sh ====
#!/bin/bash
# build and run the testbench with Verilator, verdict taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f list.f --top-module tb_axi_lite_regs \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1

grep -q "\*\*\* TEST PASSED \*\*\*" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== dv/tb_axi_lite_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_lite_regs;

    import axi_regs_pkg::*;

    localparam int TIMEOUT_CYCLES = 100;

    logic        clk;
    logic        resetn;
    axi_wr_req_t wr_req;
    axi_wr_rsp_t wr_rsp;
    axi_rd_req_t rd_req;
    axi_rd_rsp_t rd_rsp;
    reg_array_t  reg_out;
    reg_array_t  reg_in;

    // expected register contents
    reg_array_t  model;

    // results waiting for the compare process
    string       name_q[$];
    word_t       exp_q[$];
    word_t       act_q[$];
    int          error_count;

    axi_lite_regs uut
    (
        .clk     (clk),
        .resetn  (resetn),
        .wr_req  (wr_req),
        .wr_rsp  (wr_rsp),
        .rd_req  (rd_req),
        .rd_rsp  (rd_rsp),
        .reg_out (reg_out),
        .reg_in  (reg_in)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ============================================================
    // reference model
    // ============================================================
    function automatic reg_array_t model_write(reg_array_t cur, reg_index_t idx,
                                               word_t data, logic [3:0] strb);
        reg_array_t nxt;
        nxt = cur;
        if (idx < NUM_REGS)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (strb[b])
                begin
                    nxt[idx[4:0]][b*8 +: 8] = data[b*8 +: 8];
                end
            end
        end
        return nxt;
    endfunction

    function automatic word_t expected_read(reg_array_t status, reg_index_t idx);
        if (idx < NUM_REGS)
        begin
            return status[idx[4:0]];
        end
        return 32'hDEADBEEF;
    endfunction

    // ============================================================
    // checking
    // ============================================================
    task automatic check_value(input string name, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            error_count++;
            $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout: %s did not happen in time", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping on timeout");
    endtask

    task automatic record(input string name, input word_t exp, input word_t act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    task automatic record_reg_out(input string name);
        for (int i = 0; i < NUM_REGS; i++)
        begin
            record($sformatf("%s reg_out[%0d]", name, i), model[i], reg_out[i]);
        end
    endtask

    // compare process, drains results on every rising edge
    initial
    begin
        forever
        begin
            @(posedge clk);
            while (act_q.size() > 0)
            begin
                check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
            end
        end
    end

    // ============================================================
    // stimulus tasks
    // ============================================================
    task automatic write_reg(input string name, input reg_index_t idx, input word_t data,
                             input logic [3:0] strb, input int stall);
        int cycles;
        int waited;
        cycles = 0;
        waited = 0;
        @(posedge clk);
        wr_req.awaddr  <= {24'h0, idx, 2'b00};
        wr_req.awvalid <= 1'b1;
        wr_req.wdata   <= data;
        wr_req.wstrb   <= strb;
        wr_req.wvalid  <= 1'b1;
        @(negedge clk);
        cycles++;
        while (!(wr_rsp.awready && wr_rsp.wready))
        begin
            if (waited >= TIMEOUT_CYCLES)
                fail_timeout("write address and data accept");
            @(negedge clk);
            cycles++;
            waited++;
        end
        @(posedge clk);
        wr_req.awvalid <= 1'b0;
        wr_req.wvalid  <= 1'b0;
        @(negedge clk);
        cycles++;
        waited = 0;
        while (!wr_rsp.bvalid)
        begin
            if (waited >= TIMEOUT_CYCLES)
                fail_timeout("write response");
            @(negedge clk);
            cycles++;
            waited++;
        end
        // presented, seen by the DUT, readies, then bvalid
        record({name, " latency"}, 32'd3, word_t'(cycles));
        record({name, " bresp"}, 32'd0, {30'h0, wr_rsp.bresp});
        model = model_write(model, idx, data, strb);
        record_reg_out(name);
        repeat (stall)
        begin
            @(negedge clk);
            record({name, " bvalid held"}, 32'd1, {31'h0, wr_rsp.bvalid});
        end
        @(posedge clk);
        wr_req.bready <= 1'b1;
        @(posedge clk);
        wr_req.bready <= 1'b0;
        @(negedge clk);
        record({name, " bvalid cleared"}, 32'd0, {31'h0, wr_rsp.bvalid});
    endtask

    task automatic read_reg(input string name, input reg_index_t idx, input int stall);
        int    waited;
        word_t first_data;
        waited = 0;
        @(posedge clk);
        rd_req.araddr  <= {24'h0, idx, 2'b00};
        rd_req.arvalid <= 1'b1;
        @(negedge clk);
        while (!rd_rsp.arready)
        begin
            if (waited >= TIMEOUT_CYCLES)
                fail_timeout("read address accept");
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        rd_req.arvalid <= 1'b0;
        @(negedge clk);
        waited = 0;
        while (!rd_rsp.rvalid)
        begin
            if (waited >= TIMEOUT_CYCLES)
                fail_timeout("read data valid");
            @(negedge clk);
            waited++;
        end
        first_data = rd_rsp.rdata;
        record({name, " rdata"}, expected_read(reg_in, idx), first_data);
        record({name, " rresp"}, 32'd0, {30'h0, rd_rsp.rresp});
        repeat (stall)
        begin
            // status input moves while the response is held
            @(posedge clk);
            reg_in[idx[4:0]] <= ~reg_in[idx[4:0]];
            @(negedge clk);
            record({name, " rvalid held"}, 32'd1, {31'h0, rd_rsp.rvalid});
            record({name, " rdata held"}, first_data, rd_rsp.rdata);
        end
        @(posedge clk);
        rd_req.rready <= 1'b1;
        @(posedge clk);
        rd_req.rready <= 1'b0;
        @(negedge clk);
        record({name, " rvalid cleared"}, 32'd0, {31'h0, rd_rsp.rvalid});
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial
    begin
        int waited;
        void'($urandom(32'h6c1f));
        wr_req      = '0;
        rd_req      = '0;
        reg_in      = '0;
        resetn      = 1'b0;
        model       = '0;
        error_count = 0;
        waited      = 0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;

        @(negedge clk);
        record_reg_out("after_reset");
        record("after_reset bvalid", 32'd0, {31'h0, wr_rsp.bvalid});
        record("after_reset rvalid", 32'd0, {31'h0, rd_rsp.rvalid});
        record("after_reset awready", 32'd0, {31'h0, wr_rsp.awready});
        record("after_reset wready", 32'd0, {31'h0, wr_rsp.wready});
        record("after_reset arready", 32'd0, {31'h0, rd_rsp.arready});
        record("after_reset rdata", 32'd0, rd_rsp.rdata);

        repeat (20)
            write_reg("full_strobe", reg_index_t'($urandom_range(0, 31)), $urandom, 4'hF, 0);
        repeat (20)
            write_reg("partial_strobe", reg_index_t'($urandom_range(0, 31)), $urandom,
                      4'($urandom_range(0, 15)), 0);

        // random status inputs
        @(posedge clk);
        for (int i = 0; i < NUM_REGS; i++)
            reg_in[i] <= $urandom;
        repeat (20)
            read_reg("mapped_read", reg_index_t'($urandom_range(0, 31)), 0);
        repeat (10)
            read_reg("unmapped_read", reg_index_t'($urandom_range(32, 63)), 0);
        repeat (5)
            write_reg("unmapped_write", reg_index_t'($urandom_range(32, 63)), $urandom, 4'hF, 0);

        // back-pressure on B and R
        repeat (10)
            write_reg("stalled_write", reg_index_t'($urandom_range(0, 31)), $urandom,
                      4'($urandom_range(0, 15)), $urandom_range(1, 8));
        repeat (10)
            read_reg("stalled_read", reg_index_t'($urandom_range(0, 63)), $urandom_range(1, 8));

        while (act_q.size() > 0)
        begin
            if (waited >= TIMEOUT_CYCLES)
                fail_timeout("compare queue drain");
            @(negedge clk);
            waited++;
        end
        if (error_count == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/axi_lite_regs_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_regs_assertions
(
    input wire                              clk,
    input wire                              resetn,
    input wire axi_regs_pkg::axi_wr_req_t   wr_req,
    input wire axi_regs_pkg::axi_wr_rsp_t   wr_rsp,
    input wire axi_regs_pkg::axi_rd_req_t   rd_req,
    input wire axi_regs_pkg::axi_rd_rsp_t   rd_rsp
);

    import axi_regs_pkg::*;

    // ============================================================
    // write side
    // ============================================================
    // address and data are accepted in the same cycle
    assert property (@(posedge clk) disable iff (!resetn)
        wr_rsp.awready == wr_rsp.wready)
    else $error("awready and wready differ");

    assert property (@(posedge clk) disable iff (!resetn)
        wr_rsp.awready |=> !wr_rsp.awready)
    else $error("awready held longer than one cycle");

    assert property (@(posedge clk) disable iff (!resetn)
        (wr_rsp.bvalid && !wr_req.bready) |=> wr_rsp.bvalid)
    else $error("bvalid dropped before bready");

    // ============================================================
    // read side
    // ============================================================
    assert property (@(posedge clk) disable iff (!resetn)
        (rd_rsp.rvalid && !rd_req.rready) |=> (rd_rsp.rvalid && $stable(rd_rsp.rdata)))
    else $error("rvalid or rdata changed before rready");

    // sync reset, so outputs are low the cycle after any reset edge
    assert property (@(posedge clk)
        !resetn |=> !(wr_rsp.awready || wr_rsp.wready || wr_rsp.bvalid ||
                      rd_rsp.arready || rd_rsp.rvalid))
    else $error("ready or valid output high during reset");

endmodule

bind axi_lite_regs axi_lite_regs_assertions u_assertions
(
    .clk    (clk),
    .resetn (resetn),
    .wr_req (wr_req),
    .wr_rsp (wr_rsp),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp)
);

`default_nettype wire

// ==== source/axi_lite_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_regs
(
    input  wire                        clk,
    input  wire                        resetn,

    // AXI4-Lite write side
    input  wire axi_regs_pkg::axi_wr_req_t  wr_req,
    output axi_regs_pkg::axi_wr_rsp_t  wr_rsp,

    // AXI4-Lite read side
    input  wire axi_regs_pkg::axi_rd_req_t  rd_req,
    output axi_regs_pkg::axi_rd_rsp_t  rd_rsp,

    // control outputs and status inputs
    output axi_regs_pkg::reg_array_t   reg_out,
    input  wire axi_regs_pkg::reg_array_t   reg_in
);

    import axi_regs_pkg::*;

    // ============================================================
    // internal connections
    // ============================================================
    // write command from the write channel into the bank
    reg_write_t reg_write;

    // ============================================================
    // write path
    // ============================================================
    axi_write_channel u_write_channel
    (
        .clk       (clk),
        .resetn    (resetn),
        .wr_req    (wr_req),
        .wr_rsp    (wr_rsp),
        .reg_write (reg_write)
    );

    reg_bank u_reg_bank
    (
        .clk       (clk),
        .resetn    (resetn),
        .reg_write (reg_write),
        .reg_out   (reg_out)
    );

    // ============================================================
    // read path
    // ============================================================
    // reads see the status inputs, not the bank contents
    axi_read_channel u_read_channel
    (
        .clk       (clk),
        .resetn    (resetn),
        .rd_req    (rd_req),
        .rd_rsp    (rd_rsp),
        .reg_in    (reg_in)
    );

endmodule

`default_nettype wire

// ==== axi_slave/axi_read_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_read_channel
(
    input  wire                       clk,
    input  wire                       resetn,
    input  wire axi_regs_pkg::axi_rd_req_t rd_req,
    output axi_regs_pkg::axi_rd_rsp_t rd_rsp,
    input  wire axi_regs_pkg::reg_array_t  reg_in
);

    import axi_regs_pkg::*;

    // ============================================================
    // handshake state
    // ============================================================
    logic       arready_q;
    logic       rvalid_q;
    word_t      rdata_q;
    reg_index_t ar_index_q;

    // new read address seen and not yet acknowledged
    logic       ar_start;

    // capture enable, blocked while a response is still held
    logic       rd_en;

    // word picked from the status inputs for the latched index
    word_t      rd_word;

    assign ar_start = ~arready_q && rd_req.arvalid;
    assign rd_en    = arready_q && rd_req.arvalid && ~rvalid_q;

    // ============================================================
    // address channel
    // ============================================================
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            arready_q <= 1'b0;
        end
        else
        begin
            arready_q <= ar_start;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ar_start)
        begin
            ar_index_q <= rd_req.araddr[ADDR_LSB +: INDEX_WIDTH];
        end
    end

    // ============================================================
    // read data select
    // ============================================================
    // indices 32..63 never match and fall through to the pattern
    always_comb
    begin
        rd_word = UNMAPPED_DATA;
        for (int i = 0; i < NUM_REGS; i++)
        begin
            if (ar_index_q == reg_index_t'(i))
            begin
                rd_word = reg_in[i];
            end
        end
    end

    // ============================================================
    // data channel
    // ============================================================
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            rdata_q <= '0;
        end
        else if (rd_en)
        begin
            rdata_q <= rd_word;
        end
    end

    // rdata only moves on rd_en, so it stays put while rvalid waits
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            rvalid_q <= 1'b0;
        end
        else if (rd_en)
        begin
            rvalid_q <= 1'b1;
        end
        else if (rvalid_q && rd_req.rready)
        begin
            rvalid_q <= 1'b0;
        end
    end

    assign rd_rsp = '{
        arready: arready_q,
        rdata:   rdata_q,
        rresp:   RESP_OKAY,
        rvalid:  rvalid_q
    };

endmodule

`default_nettype wire

// ==== axi_slave/axi_write_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_write_channel
(
    input  wire                       clk,
    input  wire                       resetn,
    input  wire axi_regs_pkg::axi_wr_req_t wr_req,
    output axi_regs_pkg::axi_wr_rsp_t wr_rsp,
    output axi_regs_pkg::reg_write_t  reg_write
);

    import axi_regs_pkg::*;

    // ============================================================
    // handshake state
    // ============================================================
    logic       awready_q;
    logic       wready_q;
    logic       bvalid_q;
    reg_index_t aw_index_q;

    // address and data present together, not yet acknowledged
    logic       aw_start;
    logic       w_start;

    // both channels complete in this cycle
    logic       wr_fire;

    assign aw_start = ~awready_q && wr_req.awvalid && wr_req.wvalid;
    assign w_start  = ~wready_q && wr_req.wvalid && wr_req.awvalid;

    assign wr_fire  = awready_q && wr_req.awvalid && wready_q && wr_req.wvalid;

    // ============================================================
    // address and data ready pulses
    // ============================================================
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            awready_q <= 1'b0;
        end
        else
        begin
            awready_q <= aw_start;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            wready_q <= 1'b0;
        end
        else
        begin
            wready_q <= w_start;
        end
    end

    // only the index field of the address is kept
    always_ff @(posedge clk)
    begin
        if (aw_start)
        begin
            aw_index_q <= wr_req.awaddr[ADDR_LSB +: INDEX_WIDTH];
        end
    end

    // ============================================================
    // write response
    // ============================================================
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            bvalid_q <= 1'b0;
        end
        else if (wr_fire && !bvalid_q)
        begin
            bvalid_q <= 1'b1;
        end
        else if (bvalid_q && wr_req.bready)
        begin
            bvalid_q <= 1'b0;
        end
    end

    // data and strobes go straight from the bus in the accept cycle
    assign reg_write = '{
        en:    wr_fire,
        index: aw_index_q,
        data:  wr_req.wdata,
        strb:  wr_req.wstrb
    };

    // every write completes with OKAY
    assign wr_rsp = '{
        awready: awready_q,
        wready:  wready_q,
        bresp:   RESP_OKAY,
        bvalid:  bvalid_q
    };

endmodule

`default_nettype wire

// ==== source/reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_bank
(
    input  wire                       clk,
    input  wire                       resetn,
    input  wire axi_regs_pkg::reg_write_t reg_write,
    output axi_regs_pkg::reg_array_t  reg_out
);

    import axi_regs_pkg::*;

    // ============================================================
    // control register storage
    // ============================================================
    reg_array_t regs_q;

    // one-hot select of the addressed register
    logic [NUM_REGS-1:0] reg_sel;

    // index compare only covers the mapped range,
    // so a command to 32..63 selects nothing
    always_comb
    begin
        for (int i = 0; i < NUM_REGS; i++)
        begin
            reg_sel[i] = reg_write.en && (reg_write.index == reg_index_t'(i));
        end
    end

    // ============================================================
    // strobed update
    // ============================================================
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            regs_q <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                if (reg_sel[i])
                begin
                    // merge only the enabled byte lanes
                    for (int b = 0; b < STRB_WIDTH; b++)
                    begin
                        if (reg_write.strb[b])
                        begin
                            regs_q[i][b*8 +: 8] <= reg_write.data[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

    assign reg_out = regs_q;

endmodule

`default_nettype wire

// ==== common/axi_regs_pkg.sv ====
`default_nettype none

package axi_regs_pkg;

    // ============================================================
    // bus and register map geometry
    // ============================================================
    localparam int ADDR_WIDTH  = 32;
    localparam int DATA_WIDTH  = 32;
    localparam int STRB_WIDTH  = DATA_WIDTH / 8;

    // register index sits above the byte offset within a word
    localparam int ADDR_LSB    = 2;
    localparam int INDEX_WIDTH = 6;
    localparam int NUM_REGS    = 32;

    // returned for any index at or above NUM_REGS
    localparam logic [DATA_WIDTH-1:0] UNMAPPED_DATA = 32'hDEADBEEF;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // ============================================================
    // data types
    // ============================================================
    typedef logic [DATA_WIDTH-1:0]  word_t;
    typedef logic [INDEX_WIDTH-1:0] reg_index_t;

    // entry i is register i, used for both outputs and status inputs
    typedef word_t [NUM_REGS-1:0] reg_array_t;

    // master side of the write channels
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] awaddr;
        logic                  awvalid;
        word_t                 wdata;
        logic [STRB_WIDTH-1:0] wstrb;
        logic                  wvalid;
        logic                  bready;
    } axi_wr_req_t;

    // slave side of the write channels
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic [1:0] bresp;
        logic       bvalid;
    } axi_wr_rsp_t;

    // master side of the read channels
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] araddr;
        logic                  arvalid;
        logic                  rready;
    } axi_rd_req_t;

    // slave side of the read channels
    typedef struct packed {
        logic       arready;
        word_t      rdata;
        logic [1:0] rresp;
        logic       rvalid;
    } axi_rd_rsp_t;

    // one strobed write into the register bank
    typedef struct packed {
        logic                  en;
        reg_index_t            index;
        word_t                 data;
        logic [STRB_WIDTH-1:0] strb;
    } reg_write_t;

endpackage

`default_nettype wire
